//--- src/pwmTimingPkg.sv
package pwmTimingPkg;

	//////////////////////////////
	// Period and level counts
	//////////////////////////////

	localparam int PeriodCycles = 18; // Clocks per PWM period.
	localparam int NumLevels = 8; // Duty levels 0 to 7.

	// Wide enough to hold PeriodCycles itself as a limit.
	localparam int PhaseWidth = $clog2(PeriodCycles + 1);
	localparam int LevelWidth = $clog2(NumLevels);

	//////////////////////////////
	// Types
	//////////////////////////////

	typedef logic [PhaseWidth-1:0] phase_t;
	typedef logic [LevelWidth-1:0] level_t;
	typedef logic [NumLevels-1:0] dutyLevels_t;

	localparam phase_t PeriodLast = phase_t'(PeriodCycles - 1); // Wrap point.

	// A level is high while the phase is below its limit.
	localparam phase_t LevelLimit [NumLevels] = '{
		phase_t'(0), // Never high.
		phase_t'(3),
		phase_t'(6),
		phase_t'(9),
		phase_t'(12),
		phase_t'(15),
		phase_t'(16),
		phase_t'(PeriodCycles) // Always high.
	};

endpackage

//--- src/motorCmdPkg.sv
package motorCmdPkg;

	//////////////////////////////
	// Channel addressing
	//////////////////////////////

	localparam int MaxChannels = 64; // Upper bound for the index.
	localparam int ChannelIdxWidth = $clog2(MaxChannels);

	typedef logic [ChannelIdxWidth-1:0] channelIdx_t;

	//////////////////////////////
	// Command and pin types
	//////////////////////////////

	// All zero is level 0 in reverse, both pins low.
	typedef struct packed {
		logic forward; // Waveform on the forward pin.
		pwmTimingPkg::level_t level;
	} channelSetting_t;

	typedef struct packed {
		channelIdx_t channel;
		channelSetting_t setting;
	} motorCmd_t;

	typedef struct packed {
		logic fwdPin;
		logic revPin;
	} bridgePins_t;

endpackage

//--- src/dutyTimebase.sv
`timescale 1ns/1ps

module dutyTimebase (
	input  logic                      clk,
	input  logic                      rst,
	output pwmTimingPkg::dutyLevels_t levels,
	output logic                      periodEnd,
	output logic                      periodSync
);
	import pwmTimingPkg::*;

	phase_t phase;
	dutyLevels_t levelsNext;
	logic levelsAtStart;

	//////////////////////////////
	// Phase counter
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= '0;
		end else if (phase == PeriodLast) begin
			phase <= '0; // Wrap after the last phase.
		end else begin
			phase <= phase + 1'b1;
		end
	end

	//////////////////////////////
	// Level vector and markers
	//////////////////////////////

	always_comb begin
		for (int k = 0; k < NumLevels; k++) begin
			levelsNext[k] = (phase < LevelLimit[k]);
		end
	end

	// levels runs one cycle behind the phase counter.
	// periodEnd flags levels at the last phase, levelsAtStart flags
	// levels at phase 0, and periodSync lines up with the pin register.
	always_ff @(posedge clk) begin
		if (rst) begin
			levels <= '0;
			periodEnd <= 1'b0;
			levelsAtStart <= 1'b0;
			periodSync <= 1'b0;
		end else begin
			levels <= levelsNext;
			periodEnd <= (phase == PeriodLast); // Same edge as levels.
			levelsAtStart <= periodEnd;
			periodSync <= levelsAtStart; // Pins show phase 0.
		end
	end

endmodule

//--- src/commandLoader.sv
`timescale 1ns/1ps

module commandLoader #(
	parameter int NumChannels = 48
) (
	input  logic                         clk,
	input  logic                         rst,
	input  motorCmdPkg::motorCmd_t       cmd,
	input  logic                         cmdValid,
	output logic                         cmdReady,
	input  logic                         periodEnd,
	output motorCmdPkg::channelSetting_t settings [NumChannels]
);
	import motorCmdPkg::*;

	motorCmd_t pending;
	logic pendingFull;
	logic accept;
	logic applyNow;

	//////////////////////////////
	// Command handshake
	//////////////////////////////

	assign cmdReady = !pendingFull; // One-deep buffer.
	assign accept = cmdValid && cmdReady;

	// Only a command already held is applied at the boundary.
	assign applyNow = pendingFull && periodEnd;

	always_ff @(posedge clk) begin
		if (rst) begin
			pendingFull <= 1'b0;
		end else if (accept) begin
			pendingFull <= 1'b1;
		end else if (applyNow) begin
			pendingFull <= 1'b0; // Ready again from the boundary.
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			pending <= cmd;
		end
	end

	//////////////////////////////
	// Channel settings
	//////////////////////////////

	// Indexes at or above NumChannels match no entry and are dropped.
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NumChannels; i++) begin
				settings[i] <= '0; // Level 0, both pins low.
			end
		end else if (applyNow) begin
			for (int i = 0; i < NumChannels; i++) begin
				if (int'(pending.channel) == i) begin
					settings[i] <= pending.setting;
				end
			end
		end
	end

endmodule

//--- src/bridgeChannel.sv
`timescale 1ns/1ps

module bridgeChannel (
	input  logic                         clk,
	input  logic                         rst,
	input  motorCmdPkg::channelSetting_t setting,
	input  pwmTimingPkg::dutyLevels_t    levels,
	output motorCmdPkg::bridgePins_t     pins
);
	import motorCmdPkg::*;

	logic levelBit;
	bridgePins_t pinsNext;

	assign levelBit = levels[setting.level]; // Selected duty waveform.

	//////////////////////////////
	// Direction steering
	//////////////////////////////

	always_comb begin
		pinsNext = '0; // Idle side stays low.
		if (setting.forward) begin
			pinsNext.fwdPin = levelBit;
		end else begin
			pinsNext.revPin = levelBit;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pins <= '0;
		end else begin
			pins <= pinsNext;
		end
	end

endmodule

//--- src/motorPwmTop.sv
`timescale 1ns/1ps

module motorPwmTop #(
	parameter int NumChannels = 48
) (
	input  logic                     clk,
	input  logic                     rst,
	input  motorCmdPkg::motorCmd_t   cmd,
	input  logic                     cmdValid,
	output logic                     cmdReady,
	output motorCmdPkg::bridgePins_t pins [NumChannels],
	output logic                     periodSync
);
	import pwmTimingPkg::*;
	import motorCmdPkg::*;

	dutyLevels_t levels;
	logic periodEnd;
	channelSetting_t settings [NumChannels];

	//////////////////////////////
	// Shared timebase
	//////////////////////////////

	dutyTimebase timebase (
		.clk        (clk),
		.rst        (rst),
		.levels     (levels),
		.periodEnd  (periodEnd),
		.periodSync (periodSync)
	);

	//////////////////////////////
	// Command intake
	//////////////////////////////

	commandLoader #(
		.NumChannels (NumChannels)
	) loader (
		.clk       (clk),
		.rst       (rst),
		.cmd       (cmd),
		.cmdValid  (cmdValid),
		.cmdReady  (cmdReady),
		.periodEnd (periodEnd),
		.settings  (settings)
	);

	//////////////////////////////
	// Channel array
	//////////////////////////////

	for (genvar i = 0; i < NumChannels; i++) begin : gChannel
		bridgeChannel channel (
			.clk     (clk),
			.rst     (rst),
			.setting (settings[i]),
			.levels  (levels), // Same level vector for all.
			.pins    (pins[i])
		);
	end

endmodule

//--- testbench/motorPwm_assertions.sv
`timescale 1ns/1ps

module motorPwmAssertions #(
	parameter int NumChannels = 48
) (
	input logic                     clk,
	input logic                     rst,
	input motorCmdPkg::motorCmd_t   cmd,
	input logic                     cmdValid,
	input logic                     cmdReady,
	input motorCmdPkg::bridgePins_t pins [NumChannels]
);
	int bothHighFails = 0;
	int readyFails = 0;
	int stableFails = 0;
	int failCount;
	logic anyBothHigh;

	assign failCount = bothHighFails + readyFails + stableFails;

	always_comb begin
		anyBothHigh = 1'b0;
		for (int i = 0; i < NumChannels; i++) begin
			anyBothHigh |= pins[i].fwdPin && pins[i].revPin; // Shoot-through.
		end
	end

	noShootThrough: assert property (@(posedge clk) disable iff (rst) !anyBothHigh)
	else begin
		bothHighFails++;
		$error("A bridge channel drives both pins high");
	end

	readyDropsAfterAccept: assert property (@(posedge clk) disable iff (rst)
		cmdValid && cmdReady |=> !cmdReady)
	else begin
		readyFails++;
		$error("cmdReady still high in the cycle after an accept");
	end

	cmdHeldWhileWaiting: assert property (@(posedge clk) disable iff (rst)
		cmdValid && !cmdReady |=> cmdValid && $stable(cmd))
	else begin
		stableFails++;
		$error("cmd changed or dropped while waiting for cmdReady");
	end

endmodule

bind motorPwmTop motorPwmAssertions #(
	.NumChannels (NumChannels)
) assertions_i (
	.clk      (clk),
	.rst      (rst),
	.cmd      (cmd),
	.cmdValid (cmdValid),
	.cmdReady (cmdReady),
	.pins     (pins)
);

//--- testbench/motorPwmChecker.sv
`timescale 1ns/1ps

module motorPwmChecker #(
	parameter int NumChannels = 48
) (
	input  logic                     clk,
	input  logic                     rst,
	input  motorCmdPkg::motorCmd_t   cmd,
	input  logic                     cmdValid,
	input  logic                     cmdReady,
	input  motorCmdPkg::bridgePins_t pins [NumChannels],
	input  logic                     periodSync,
	output int                       errorCount,
	output int                       pinChecks,
	output int                       readyChecks,
	output int                       appliedCount,
	output int                       droppedCount
);
	import pwmTimingPkg::*;
	import motorCmdPkg::*;

	typedef struct packed {
		motorCmd_t command;
		int acceptCycle;
	} heldCmd_t;

	channelSetting_t model [NumChannels];
	heldCmd_t heldQ [$];
	int errors = 0;
	int pinCount = 0;
	int readyCount = 0;
	int applied = 0;
	int dropped = 0;
	int cycle;
	int phase;
	logic phaseKnown;
	logic busy; // A command waits for its boundary.
	int busyCycle;

	assign errorCount = errors;
	assign pinChecks = pinCount;
	assign readyChecks = readyCount;
	assign appliedCount = applied;
	assign droppedCount = dropped;

	function automatic int highPhases(input int lvl);
		case (lvl)
			0: return 0;
			6: return 16;
			7: return PeriodCycles;
			default: return 3 * lvl; // Levels 1 to 5.
		endcase
	endfunction

	function automatic bridgePins_t expectedPins(input channelSetting_t s, input int ph);
		bridgePins_t p;
		logic on;
		on = ph < highPhases(int'(s.level));
		p = '0;
		if (s.forward) begin
			p.fwdPin = on;
		end else begin
			p.revPin = on;
		end
		return p;
	endfunction

	//////////////////////////////
	// Per-cycle model and compare
	//////////////////////////////

	always @(negedge clk) begin : sampleCycle
		heldCmd_t held;
		bridgePins_t want;
		if (rst) begin
			for (int i = 0; i < NumChannels; i++) begin
				model[i] = '0;
			end
			heldQ.delete();
			cycle = 0;
			phase = 0;
			phaseKnown = 1'b0;
			busy = 1'b0;
		end else begin
			cycle++;
			if (periodSync) begin
				if (phaseKnown && phase != PeriodCycles - 1) begin
					errors++;
					$display("CHECK FAILED at %0t: periodSync after %0d phases, expected %0d",
						$time, phase + 1, PeriodCycles);
				end
				phase = 0;
				phaseKnown = 1'b1;
			end else if (phaseKnown) begin
				phase++;
				if (phase == PeriodCycles) begin
					errors++;
					$display("CHECK FAILED at %0t: periodSync missing at period end", $time);
					phase = 0;
				end
			end
			// Commands from at least two edges back take effect here.
			while (periodSync && heldQ.size() > 0 && heldQ[0].acceptCycle <= cycle - 3) begin
				held = heldQ.pop_front();
				if (int'(held.command.channel) < NumChannels) begin
					model[held.command.channel] = held.command.setting;
					applied++;
				end else begin
					dropped++;
				end
			end
			if (busy && periodSync && cycle >= busyCycle + 3) begin
				busy = 1'b0;
			end
			// Buffer frees one cycle before the sync.
			if (busy && phaseKnown && phase == PeriodCycles - 1 && cycle >= busyCycle + 2) begin
				busy = 1'b0;
			end
			if (phaseKnown || !busy) begin
				readyCount++;
				if (cmdReady !== !busy) begin
					errors++;
					$display("CHECK FAILED at %0t: cmdReady is %b, expected %b",
						$time, cmdReady, !busy);
				end
			end
			for (int ch = 0; ch < NumChannels; ch++) begin
				want = expectedPins(model[ch], phase);
				pinCount++;
				if (pins[ch] !== want) begin
					errors++;
					$display("CHECK FAILED at %0t: channel %0d pins %b, expected %b",
						$time, ch, pins[ch], want);
				end
			end
			if (cmdValid && cmdReady) begin
				heldQ.push_back('{command: cmd, acceptCycle: cycle});
				busy = 1'b1;
				busyCycle = cycle;
			end
		end
	end

endmodule

//--- testbench/motorPwmTb.sv
`timescale 1ns/1ps

module motorPwmTb;
	import pwmTimingPkg::*;
	import motorCmdPkg::*;

	localparam int NumChannels = 48;
	localparam int NumCommands = 300;
	localparam int TimeoutCycles = NumCommands * (PeriodCycles + 8) + 200;

	logic clk;
	logic rst = 1'b1;
	motorCmd_t cmd = '0;
	logic cmdValid = 1'b0;
	logic cmdReady;
	bridgePins_t pins [NumChannels];
	logic periodSync;

	int seed = 39354;
	int cycleCount = 0;
	int gap;
	int errorCount;
	int pinChecks;
	int readyChecks;
	int appliedCount;
	int droppedCount;

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period.
	end

	motorPwmTop #(
		.NumChannels (NumChannels)
	) dut_i (
		.clk        (clk),
		.rst        (rst),
		.cmd        (cmd),
		.cmdValid   (cmdValid),
		.cmdReady   (cmdReady),
		.pins       (pins),
		.periodSync (periodSync)
	);

	motorPwmChecker #(
		.NumChannels (NumChannels)
	) checker_i (
		.clk          (clk),
		.rst          (rst),
		.cmd          (cmd),
		.cmdValid     (cmdValid),
		.cmdReady     (cmdReady),
		.pins         (pins),
		.periodSync   (periodSync),
		.errorCount   (errorCount),
		.pinChecks    (pinChecks),
		.readyChecks  (readyChecks),
		.appliedCount (appliedCount),
		.droppedCount (droppedCount)
	);

	//////////////////////////////
	// Stimulus helpers
	//////////////////////////////

	// About one command in eight targets a channel that does not exist.
	function automatic motorCmd_t randomCommand();
		motorCmd_t next;
		int pick;
		pick = $unsigned($random(seed)) % 8;
		if (pick == 0 && NumChannels < MaxChannels) begin
			next.channel = channelIdx_t'(NumChannels
				+ $unsigned($random(seed)) % (MaxChannels - NumChannels));
		end else begin
			next.channel = channelIdx_t'($unsigned($random(seed)) % NumChannels);
		end
		next.setting.level = level_t'($unsigned($random(seed)) % NumLevels);
		next.setting.forward = 1'($random(seed) & 1);
		return next;
	endfunction

	// Called on a rising edge, returns on the transfer edge.
	task automatic sendCommand(input motorCmd_t next);
		cmd <= next;
		cmdValid <= 1'b1;
		do begin
			@(posedge clk);
		end while (!cmdReady);
		cmdValid <= 1'b0;
	endtask

	task automatic finishRun(input logic timedOut);
		int totalErrors;
		totalErrors = errorCount + dut_i.assertions_i.failCount;
		$display("Summary: %0d pin checks, %0d ready checks, %0d applied, %0d dropped, %0d errors",
			pinChecks, readyChecks, appliedCount, droppedCount, totalErrors);
		if (totalErrors == 0 && !timedOut) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		for (int n = 0; n < NumCommands; n++) begin
			gap = $unsigned($random(seed)) % 8; // Idle cycles before the next command.
			repeat (gap) @(posedge clk);
			sendCommand(randomCommand());
		end
		do begin
			@(posedge clk);
		end while (!cmdReady);
		// One sync applies the last command, the next one ends its first period.
		repeat (2) begin
			do begin
				@(posedge clk);
			end while (!periodSync);
		end
		finishRun(1'b0);
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount == TimeoutCycles) begin
			$display("Timeout: the command sequence did not finish within %0d cycles",
				TimeoutCycles);
			finishRun(1'b1);
		end
	end

endmodule

//--- vlog.f
src/pwmTimingPkg.sv
src/motorCmdPkg.sv
src/dutyTimebase.sv
src/commandLoader.sv
src/bridgeChannel.sv
src/motorPwmTop.sv
testbench/motorPwm_assertions.sv
testbench/motorPwmChecker.sv
testbench/motorPwmTb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module motorPwmTb -f vlog.f -o motorPwmSim &&
{ ./obj_dir/motorPwmSim +verilator+error+limit+1000 > sim.log 2>&1 || true; } &&
grep -qx "NO ERRORS" sim.log &&
echo "Simulation passed" ||
{ echo "Simulation failed, see sim.log"; exit 1; }
